// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and look for the pass line in the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module iram_tb -f src.f -o iram_sim \
   && ./obj_dir/iram_sim 2>&1 | tee sim.log \
   && grep -qx "All checks passed" sim.log \
   && echo "simulation run succeeded" \
   || { echo "simulation run failed, see sim.log"; exit 1; }

// ==== source/iram_credit_fifo.sv ====
`timescale 1ns/10ps

module iram_credit_fifo #(
   parameter type payload_t = iram_pkg::iram_req_t,
   parameter int  depth     = iram_pkg::REQ_DEPTH
) (
   input  logic     clk_a,
   input  logic     reset,
   input  logic     push,
   input  payload_t din,
   input  logic     pop,
   output logic     valid,
   output payload_t dout,
   output logic     credit
);

   typedef logic [$clog2(depth)-1:0]   ptr_t;
   typedef logic [$clog2(depth+1)-1:0] cnt_t;

   payload_t mem [depth];
   ptr_t     wr_ptr;
   ptr_t     rd_ptr;
   cnt_t     count;
   logic     do_pop;

   assign valid  = (count != '0);
   assign dout   = mem[rd_ptr];  // show-ahead head.
   assign do_pop = pop & valid;

   always_ff @(posedge clk_a)
   begin
      if (push)
      begin
         mem[wr_ptr] <= din;
      end
   end

   // ========================================================================
   // pointers, fill level and the credit pulse
   // ========================================================================

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         credit <= 1'b0;
      end
      else
      begin
         if (push)
         begin
            wr_ptr <= (wr_ptr == ptr_t'(depth - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop)
         begin
            rd_ptr <= (rd_ptr == ptr_t'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         credit <= do_pop;  // one slot freed, handed back to the sender.
      end
   end

endmodule

// ==== source/iram_dpram.sv ====
`timescale 1ns/10ps

module iram_dpram #(
   parameter int words  = 21504,
   parameter int addr_w = 15,
   parameter int data_w = 32
) (
   input  logic              clk_a,
   input  logic              reset,
   input  logic [addr_w-1:0] address_a,
   input  logic [data_w-1:0] data_a,
   input  logic              wren_a,
   input  logic              rden_a,
   output logic [data_w-1:0] q_a,
   input  logic [addr_w-1:0] address_b,
   input  logic [data_w-1:0] data_b,
   input  logic              wren_b,
   input  logic              rden_b,
   output logic [data_w-1:0] q_b
);

   logic [data_w-1:0] ram [words];

   // port b is written last, so it would win a same-address double write.
   always_ff @(posedge clk_a)
   begin
      if (wren_a)
      begin
         ram[address_a] <= data_a;
      end
      if (wren_b)
      begin
         ram[address_b] <= data_b;
      end
   end

   // write-first on each port: a write shows its own data on q.
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         q_a <= '0;
         q_b <= '0;
      end
      else
      begin
         if (wren_a | rden_a)
         begin
            q_a <= wren_a ? data_a : ram[address_a];
         end
         if (wren_b | rden_b)
         begin
            q_b <= wren_b ? data_b : ram[address_b];  // q holds when idle.
         end
      end
   end

endmodule

// ==== source/iram_pkg.sv ====
package iram_pkg;

   // ========================================================================
   // sizes
   // ========================================================================

   localparam int IRAM_WORDS = 21504;
   localparam int ADDR_W     = 15;
   localparam int DATA_W     = 32;
   localparam int TAG_W      = 4;

   // ========================================================================
   // buffering and credits
   // ========================================================================

   localparam int REQ_DEPTH   = 4;  // requester starts with this many credits.
   localparam int RSP_DEPTH   = 4;
   localparam int RSP_CREDITS = 2;  // consumer credits held per port after reset.

   // ========================================================================
   // channel payloads
   // ========================================================================

   // one request as it travels through the input buffer and the first stage.
   typedef struct packed {
      logic              write;  // high for a write, low for a read.
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;   // write data, ignored on a read.
      logic [TAG_W-1:0]  tag;
   } iram_req_t;

   // a read returns the stored word, a write echoes the written word.
   typedef struct packed {
      logic [TAG_W-1:0]  tag;
      logic [DATA_W-1:0] data;
   } iram_rsp_t;

endpackage

// ==== source/iram_port_ctrl.sv ====
`timescale 1ns/10ps

module iram_port_ctrl (
   input  logic                clk_a,
   input  logic                reset,
   input  logic                head_a_valid,
   input  iram_pkg::iram_req_t head_a,
   output logic                pop_a,
   input  logic                reserve_ok_a,
   output logic                issue_a,
   output logic                rsp_a_wr,
   output iram_pkg::iram_rsp_t rsp_a_data,
   input  logic                head_b_valid,
   input  iram_pkg::iram_req_t head_b,
   output logic                pop_b,
   input  logic                reserve_ok_b,
   output logic                issue_b,
   output logic                rsp_b_wr,
   output iram_pkg::iram_rsp_t rsp_b_data
);

   import iram_pkg::*;

   logic             can_a;
   logic             can_b;
   logic             conflict;
   logic             pop [2];
   iram_req_t        head [2];
   logic             s1_valid [2];  // stage 1 drives the RAM ports.
   iram_req_t        s1_req [2];
   logic             s2_valid [2];  // stage 2 lines up with the RAM output.
   logic [TAG_W-1:0] s2_tag [2];
   logic [DATA_W-1:0] q [2];

   // ========================================================================
   // issue decision
   // ========================================================================

   assign can_a = head_a_valid & reserve_ok_a;
   assign can_b = head_b_valid & reserve_ok_b;

   // same address with a write on either side: port a goes now, port b waits.
   assign conflict = can_a & can_b & (head_a.addr == head_b.addr)
                     & (head_a.write | head_b.write);

   assign pop_a   = can_a;
   assign pop_b   = can_b & ~conflict;
   assign issue_a = pop_a;
   assign issue_b = pop_b;

   assign pop[0]  = pop_a;
   assign pop[1]  = pop_b;
   assign head[0] = head_a;
   assign head[1] = head_b;

   // ========================================================================
   // two-stage pipeline around the RAM
   // ========================================================================

   always_ff @(posedge clk_a)
   begin
      for (int p = 0; p < 2; p++)
      begin
         s1_req[p] <= head[p];
         s2_tag[p] <= s1_req[p].tag;
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         s1_valid <= '{default: 1'b0};
         s2_valid <= '{default: 1'b0};
      end
      else
      begin
         s1_valid <= pop;
         s2_valid <= s1_valid;
      end
   end

   iram_dpram #(
      .words  (IRAM_WORDS),
      .addr_w (ADDR_W),
      .data_w (DATA_W)
   ) ram_i (
      .clk_a     (clk_a),
      .reset     (reset),
      .address_a (s1_req[0].addr),
      .data_a    (s1_req[0].data),
      .wren_a    (s1_valid[0] & s1_req[0].write),
      .rden_a    (s1_valid[0] & ~s1_req[0].write),
      .q_a       (q[0]),
      .address_b (s1_req[1].addr),
      .data_b    (s1_req[1].data),
      .wren_b    (s1_valid[1] & s1_req[1].write),
      .rden_b    (s1_valid[1] & ~s1_req[1].write),
      .q_b       (q[1])
   );

   assign rsp_a_wr   = s2_valid[0];
   assign rsp_a_data = '{tag: s2_tag[0], data: q[0]};
   assign rsp_b_wr   = s2_valid[1];
   assign rsp_b_data = '{tag: s2_tag[1], data: q[1]};

endmodule

// ==== source/iram_rsp_tx.sv ====
`timescale 1ns/10ps

module iram_rsp_tx (
   input  logic                clk_a,
   input  logic                reset,
   input  logic                issue,
   input  logic                wr,
   input  iram_pkg::iram_rsp_t din,
   input  logic                credit,
   output logic                valid,
   output iram_pkg::iram_rsp_t rsp,
   output logic                reserve_ok
);

   import iram_pkg::*;

   typedef logic [$clog2(RSP_DEPTH+1)-1:0]   rsv_cnt_t;
   typedef logic [$clog2(RSP_CREDITS+1)-1:0] crd_cnt_t;

   rsv_cnt_t reserved;   // buffered plus in-flight responses.
   crd_cnt_t credits;    // consumer credits on hand.
   logic     head_valid;
   logic     slot_free;

   // the head goes out whenever the consumer has room for it.
   assign valid      = head_valid & (credits != '0);
   assign reserve_ok = (reserved < rsv_cnt_t'(RSP_DEPTH));

   iram_credit_fifo #(
      .payload_t (iram_rsp_t),
      .depth     (RSP_DEPTH)
   ) rsp_fifo_i (
      .clk_a  (clk_a),
      .reset  (reset),
      .push   (wr),
      .din    (din),
      .pop    (valid),
      .valid  (head_valid),
      .dout   (rsp),
      .credit (slot_free)
   );

   // ========================================================================
   // slot reservation and consumer credits
   // ========================================================================

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         reserved <= '0;
         credits  <= crd_cnt_t'(RSP_CREDITS);
      end
      else
      begin
         // a slot is released when the FIFO hands back its credit.
         case ({issue, slot_free})
            2'b10:   reserved <= reserved + 1'b1;
            2'b01:   reserved <= reserved - 1'b1;
            default: reserved <= reserved;
         endcase
         case ({credit, valid})
            2'b10:   credits <= credits + 1'b1;
            2'b01:   credits <= credits - 1'b1;
            default: credits <= credits;
         endcase
      end
   end

endmodule

// ==== source/iram_top.sv ====
`timescale 1ns/10ps

module iram_top (
   input  logic                clk_a,
   input  logic                reset,
   input  logic                req_a_valid,
   input  iram_pkg::iram_req_t req_a,
   output logic                req_a_credit,
   output logic                rsp_a_valid,
   output iram_pkg::iram_rsp_t rsp_a,
   input  logic                rsp_a_credit,
   input  logic                req_b_valid,
   input  iram_pkg::iram_req_t req_b,
   output logic                req_b_credit,
   output logic                rsp_b_valid,
   output iram_pkg::iram_rsp_t rsp_b,
   input  logic                rsp_b_credit
);

   import iram_pkg::*;

   logic      head_a_valid;
   logic      head_b_valid;
   iram_req_t head_a;
   iram_req_t head_b;
   logic      pop_a;
   logic      pop_b;
   logic      reserve_ok_a;
   logic      reserve_ok_b;
   logic      issue_a;
   logic      issue_b;
   logic      rsp_a_wr;
   logic      rsp_b_wr;
   iram_rsp_t rsp_a_data;
   iram_rsp_t rsp_b_data;

   // ========================================================================
   // input side
   // ========================================================================

   iram_credit_fifo #(.payload_t(iram_req_t), .depth(REQ_DEPTH)) req_a_fifo_i (
      .clk_a(clk_a), .reset(reset), .push(req_a_valid), .din(req_a), .pop(pop_a),
      .valid(head_a_valid), .dout(head_a), .credit(req_a_credit)
   );

   iram_credit_fifo #(.payload_t(iram_req_t), .depth(REQ_DEPTH)) req_b_fifo_i (
      .clk_a(clk_a), .reset(reset), .push(req_b_valid), .din(req_b), .pop(pop_b),
      .valid(head_b_valid), .dout(head_b), .credit(req_b_credit)
   );

   // ========================================================================
   // processing and output side
   // ========================================================================

   iram_port_ctrl ctrl_i (
      .clk_a(clk_a), .reset(reset),
      .head_a_valid(head_a_valid), .head_a(head_a), .pop_a(pop_a),
      .reserve_ok_a(reserve_ok_a), .issue_a(issue_a),
      .rsp_a_wr(rsp_a_wr), .rsp_a_data(rsp_a_data),
      .head_b_valid(head_b_valid), .head_b(head_b), .pop_b(pop_b),
      .reserve_ok_b(reserve_ok_b), .issue_b(issue_b),
      .rsp_b_wr(rsp_b_wr), .rsp_b_data(rsp_b_data)
   );

   iram_rsp_tx rsp_a_tx_i (
      .clk_a(clk_a), .reset(reset), .issue(issue_a), .wr(rsp_a_wr), .din(rsp_a_data),
      .credit(rsp_a_credit), .valid(rsp_a_valid), .rsp(rsp_a), .reserve_ok(reserve_ok_a)
   );

   iram_rsp_tx rsp_b_tx_i (
      .clk_a(clk_a), .reset(reset), .issue(issue_b), .wr(rsp_b_wr), .din(rsp_b_data),
      .credit(rsp_b_credit), .valid(rsp_b_valid), .rsp(rsp_b), .reserve_ok(reserve_ok_b)
   );

endmodule

// ==== src.f ====
source/iram_pkg.sv
source/iram_dpram.sv
source/iram_credit_fifo.sv
source/iram_port_ctrl.sv
source/iram_rsp_tx.sv
source/iram_top.sv
verif/iram_chk.sv
verif/iram_tb.sv

// ==== verif/iram_chk.sv ====
`timescale 1ns/10ps

module iram_chk (
   input logic clk_a,
   input logic reset,
   input logic send,
   input logic returned,
   input logic push,
   input logic full,
   input logic credit
);

   import iram_pkg::*;

   logic [2:0] held;  // consumer credits counted from the port's own pins.

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         held <= 3'(RSP_CREDITS);
      end
      else
      begin
         held <= held + 3'(returned) - 3'(send);
      end
   end

   // ========================================================================
   // credit and valid rules
   // ========================================================================

   send_has_credit: assert property (@(posedge clk_a) disable iff (reset)
                                     !(send && held == '0))
      else $error("response sent while the consumer credit count is zero.");

   push_not_full: assert property (@(posedge clk_a) disable iff (reset) !(push && full))
      else $error("push into a full FIFO.");

   // the credit register is cleared by the first reset edge.
   credit_low_in_reset: assert property (@(posedge clk_a) reset && $past(reset) |-> !credit)
      else $error("credit pulse while reset is held.");

endmodule

bind iram_rsp_tx iram_chk rsp_tx_chk_i (
   .clk_a(clk_a), .reset(reset), .send(valid), .returned(credit),
   .push(1'b0), .full(1'b0), .credit(1'b0)
);

bind iram_credit_fifo iram_chk fifo_chk_i (
   .clk_a(clk_a), .reset(reset), .send(1'b0), .returned(1'b0),
   .push(push), .full(int'(count) == depth), .credit(credit)
);

// ==== verif/iram_tb.sv ====
`timescale 1ns/10ps

module iram_tb;

   import iram_pkg::*;

   localparam logic [31:0] SEED = 32'h6016_3ca0;
   localparam int HALF        = IRAM_WORDS / 2;  // port a streams below, port b above.
   localparam int POOL_N      = 8;
   localparam int DIRECTED_N  = 25;
   localparam int STREAM_N    = 40;
   localparam int BP_N        = 12;
   localparam int HOLD_CYCLES = 30;
   localparam int CYCLE_LIMIT = 16 + 20 * DIRECTED_N + 4 * STREAM_N + HOLD_CYCLES
                                + 8 * BP_N + 100;

   logic        clk_a = 1'b0;
   logic        reset;
   logic [1:0]  req_valid;
   iram_req_t   req [2];
   wire  [1:0]  req_credit;
   wire  [1:0]  rsp_valid;
   iram_rsp_t   rsp_a;
   iram_rsp_t   rsp_b;
   logic [1:0]  cons_pulse = 2'b00;
   logic        hold;
   logic        slow;

   iram_req_t   pend_q [2][$];
   iram_rsp_t   exp_q [2][$];
   iram_rsp_t   rx_q [2][$];
   logic [DATA_W-1:0] ref_mem [int];
   int          sent_cnt [2] = '{0, 0};
   int          ret_cnt [2] = '{0, 0};
   int          cons_ret [2] = '{0, 0};
   int          wait_cnt [2] = '{0, 0};
   int          chk_idx [2] = '{0, 0};
   int          err_cnt = 0;
   int          mon_err = 0;
   logic [31:0] lfsr_t = SEED;
   logic [31:0] lfsr_c = SEED;

   always
   begin
      #20 clk_a = ~clk_a;
   end

   iram_top dut_i (
      .clk_a(clk_a), .reset(reset),
      .req_a_valid(req_valid[0]), .req_a(req[0]), .req_a_credit(req_credit[0]),
      .rsp_a_valid(rsp_valid[0]), .rsp_a(rsp_a), .rsp_a_credit(cons_pulse[0]),
      .req_b_valid(req_valid[1]), .req_b(req[1]), .req_b_credit(req_credit[1]),
      .rsp_b_valid(rsp_valid[1]), .rsp_b(rsp_b), .rsp_b_credit(cons_pulse[1])
   );

   // ========================================================================
   // random bits, requester and consumer models
   // ========================================================================

   // fibonacci taps at 32, 22, 2 and 1.
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic rand_bits(inout logic [31:0] state, input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         state = lfsr_next(state);
         v = {v[30:0], state[0]};
      end
   endtask

   // outputs are sampled half a cycle away from the edge that changes them.
   always @(negedge clk_a)
   begin
      for (int p = 0; p < 2; p++)
      begin
         if (req_credit[p])
            ret_cnt[p]++;
         if (rsp_valid[p])
         begin
            if (rx_q[p].size() >= RSP_CREDITS + cons_ret[p])
            begin
               $display("port %0d sent a response while holding no consumer credit", p);
               mon_err++;
            end
            rx_q[p].push_back((p == 0) ? rsp_a : rsp_b);
         end
      end
   end

   // the consumer hands back one credit per response, at once or after a short delay.
   always @(posedge clk_a)
   begin
      logic [31:0] bits;
      for (int p = 0; p < 2; p++)
      begin
         cons_pulse[p] <= 1'b0;
         if (!reset && !hold && cons_ret[p] < rx_q[p].size())
         begin
            if (wait_cnt[p] == 0)
            begin
               cons_pulse[p] <= 1'b1;
               cons_ret[p]++;
               if (slow)
               begin
                  rand_bits(lfsr_c, 2, bits);
                  wait_cnt[p] = int'(bits);
               end
            end
            else
               wait_cnt[p]--;
         end
      end
   end

   // ========================================================================
   // helpers
   // ========================================================================

   task automatic compare_value(input string name, input logic [31:0] exp, input logic [31:0] got);
      if (exp !== got)
      begin
         $display("mismatch %s expected %h got %h", name, exp, got);
         err_cnt++;
      end
   endtask

   function automatic iram_req_t make_req(input logic w, input int addr, input logic [31:0] d,
                                          input int tag);
      return '{write: w, addr: ADDR_W'(addr), data: d, tag: TAG_W'(tag)};
   endfunction

   // the reference memory is updated in issue order, port a before port b.
   function automatic void predict(input int p, input iram_req_t r);
      iram_rsp_t e;
      e.tag = r.tag;
      if (r.write)
      begin
         ref_mem[int'(r.addr)] = r.data;
         e.data = r.data;
      end
      else
         e.data = ref_mem.exists(int'(r.addr)) ? ref_mem[int'(r.addr)] : '0;
      exp_q[p].push_back(e);
   endfunction

   task automatic drive_requests(input int max_cycles);
      int n;
      n = 0;
      while ((pend_q[0].size() + pend_q[1].size()) > 0 && n < max_cycles)
      begin
         @(posedge clk_a);
         for (int p = 0; p < 2; p++)
         begin
            if (pend_q[p].size() > 0 && (sent_cnt[p] - ret_cnt[p]) < REQ_DEPTH)
            begin
               req[p] <= pend_q[p][0];
               req_valid[p] <= 1'b1;
               predict(p, pend_q[p].pop_front());
               sent_cnt[p]++;
            end
            else
               req_valid[p] <= 1'b0;
         end
         n++;
      end
      @(posedge clk_a);
      req_valid <= 2'b00;
   endtask

   function automatic bit drained();
      for (int p = 0; p < 2; p++)
      begin
         if (rx_q[p].size() < exp_q[p].size() || cons_ret[p] < rx_q[p].size())
            return 1'b0;
      end
      return 1'b1;
   endfunction

   task automatic wait_drain();
      do
         @(negedge clk_a);
      while (!drained());
      repeat (2) @(negedge clk_a);
   endtask

   task automatic check_responses(input int p);
      string port;
      port = (p == 0) ? "rsp_a" : "rsp_b";
      compare_value({port, " count"}, 32'(exp_q[p].size()), 32'(rx_q[p].size()));
      for (int i = chk_idx[p]; i < exp_q[p].size() && i < rx_q[p].size(); i++)
      begin
         compare_value({port, ".tag"}, 32'(exp_q[p][i].tag), 32'(rx_q[p][i].tag));
         compare_value({port, ".data"}, exp_q[p][i].data, rx_q[p][i].data);
      end
      chk_idx[p] = exp_q[p].size();
   endtask

   task automatic run_batch();
      drive_requests(CYCLE_LIMIT);
      wait_drain();
      check_responses(0);
      check_responses(1);
   endtask

   // ========================================================================
   // directed tests
   // ========================================================================

   task automatic reset_state();
      repeat (4)
      begin
         @(negedge clk_a);
         compare_value("req_credit", 32'h0, 32'(req_credit));
         compare_value("rsp_valid", 32'h0, 32'(rsp_valid));
      end
   endtask

   task automatic write_read_port_a();
      for (int i = 0; i < 8; i++)
         pend_q[0].push_back(make_req(1'b1, 256 + i * 57, {16'hc0de, 16'(i * 4099)}, i));
      run_batch();
      for (int i = 0; i < 8; i++)
         pend_q[0].push_back(make_req(1'b0, 256 + i * 57, 32'h0, 8 + i));
      run_batch();
   endtask

   task automatic cross_port();
      pend_q[1].push_back(make_req(1'b1, 21000, 32'h5a5a_1234, 3));
      run_batch();
      pend_q[0].push_back(make_req(1'b0, 21000, 32'h0, 4));
      run_batch();
      pend_q[0].push_back(make_req(1'b1, IRAM_WORDS - 1, 32'h0bad_f00d, 5));
      run_batch();
      pend_q[1].push_back(make_req(1'b0, IRAM_WORDS - 1, 32'h0, 6));
      run_batch();
   endtask

   task automatic same_addr_conflict();
      pend_q[0].push_back(make_req(1'b1, 300, 32'h1111_aaaa, 1));  // both heads meet in one cycle.
      pend_q[1].push_back(make_req(1'b0, 300, 32'h0, 2));
      run_batch();
      pend_q[0].push_back(make_req(1'b1, 301, 32'h2222_bbbb, 5));
      pend_q[1].push_back(make_req(1'b1, 301, 32'h3333_cccc, 6));
      run_batch();
      pend_q[0].push_back(make_req(1'b0, 301, 32'h0, 7));
      run_batch();
   endtask

   task automatic streaming();
      logic [31:0] v;
      logic [31:0] d;
      logic        w;
      int          pool [2][POOL_N];
      for (int p = 0; p < 2; p++)
      begin
         for (int i = 0; i < POOL_N; i++)
         begin
            rand_bits(lfsr_t, 15, v);
            pool[p][i] = p * HALF + int'(v % HALF);
         end
      end
      // the first requests write the pool, so every later read finds a stored word.
      for (int i = 0; i < STREAM_N; i++)
      begin
         for (int p = 0; p < 2; p++)
         begin
            rand_bits(lfsr_t, 32, d);
            if (i < POOL_N)
               pend_q[p].push_back(make_req(1'b1, pool[p][i], d, i));
            else
            begin
               rand_bits(lfsr_t, 1, v);
               w = v[0];
               rand_bits(lfsr_t, 3, v);
               pend_q[p].push_back(make_req(w, pool[p][v[2:0]], d, i));
            end
         end
      end
      run_batch();
      compare_value("req_a credits returned", 32'(sent_cnt[0]), 32'(ret_cnt[0]));
      compare_value("req_b credits returned", 32'(sent_cnt[1]), 32'(ret_cnt[1]));
   endtask

   task automatic back_pressure();
      logic [31:0] d;
      int          base [2];
      hold = 1'b1;
      for (int p = 0; p < 2; p++)
      begin
         base[p] = rx_q[p].size();
         for (int i = 0; i < BP_N; i++)
         begin
            rand_bits(lfsr_t, 32, d);
            pend_q[p].push_back(make_req(i % 2 == 0, p * HALF + 500 + i / 2, d, i));
         end
      end
      drive_requests(HOLD_CYCLES);
      @(negedge clk_a);
      // only the credits held at the start may have been spent, and the buffers are full.
      compare_value("rsp_a responses", 32'(RSP_CREDITS), 32'(rx_q[0].size() - base[0]));
      compare_value("rsp_b responses", 32'(RSP_CREDITS), 32'(rx_q[1].size() - base[1]));
      compare_value("req_a credits", 32'h0, 32'(REQ_DEPTH - sent_cnt[0] + ret_cnt[0]));
      compare_value("req_b credits", 32'h0, 32'(REQ_DEPTH - sent_cnt[1] + ret_cnt[1]));
      hold = 1'b0;
      slow = 1'b1;
      run_batch();
   endtask

   initial
   begin
      int cycles;
      cycles = 0;
      while (cycles < CYCLE_LIMIT)
      begin
         @(posedge clk_a);
         cycles++;
      end
      $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Checks failed");
      $finish;
   end

   initial
   begin
      reset = 1'b1;
      req_valid = 2'b00;
      req[0] = '0;
      req[1] = '0;
      hold = 1'b0;
      slow = 1'b0;
      repeat (16) @(posedge clk_a);
      reset <= 1'b0;
      reset_state();
      write_read_port_a();
      cross_port();
      same_addr_conflict();
      streaming();
      back_pressure();
      repeat (4) @(posedge clk_a);
      $display("errors: %0d from checks, %0d from the response monitor", err_cnt, mon_err);
      if (err_cnt + mon_err == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule
